/* collision_detect.sv */
`default_nettype none

`include "tron_defs.svh"

module collision_detect (
	input  logic                   Clk,
	input  logic                   rst_n,
	// once per frame
	input  logic                   frame_tick,
	input  video_pkg::coord_t      blue_x,
	input  video_pkg::coord_t      blue_y,
	input  video_pkg::coord_t      red_x,
	input  video_pkg::coord_t      red_y,
	input  game_pkg::dir_e         blue_dir,
	input  game_pkg::dir_e         red_dir,
	// probe read port of the frame buffer
	output video_pkg::frame_addr_t probe_addr,
	input  video_pkg::frame_word_u probe_data,
	output logic                   blocked_blue,
	output logic                   blocked_red,
	output logic                   collide_valid
);
	import video_pkg::*;
	import game_pkg::*;

	// sequencer states
	localparam logic [1:0] S_IDLE = 2'd0;
	localparam logic [1:0] S_BLUE = 2'd1;
	localparam logic [1:0] S_RED  = 2'd2;

	logic [1:0] state;
	coord_t     blue_nx;
	coord_t     blue_ny;
	coord_t     red_nx;
	coord_t     red_ny;
	coord_t     cur_nx;
	coord_t     cur_ny;
	logic       cur_off;
	logic       lane_q;
	logic       off_q;
	logic       blue_q;
	logic       red_q;
	logic       nose_hit;

	// pixel just ahead of the square, centred on the leading edge
	function automatic coord_t nose_x(input coord_t x, input dir_e d);
		case (d)
			DIR_LEFT:  return x - 10'd1;
			DIR_RIGHT: return x + 10'(`BIKE_SIZE);
			default:   return x + 10'(`BIKE_SIZE / 2);
		endcase
	endfunction

	function automatic coord_t nose_y(input coord_t y, input dir_e d);
		case (d)
			DIR_UP:   return y - 10'd1;
			DIR_DOWN: return y + 10'(`BIKE_SIZE);
			default:  return y + 10'(`BIKE_SIZE / 2);
		endcase
	endfunction

	assign blue_nx = nose_x(blue_x, blue_dir);
	assign blue_ny = nose_y(blue_y, blue_dir);
	assign red_nx  = nose_x(red_x, red_dir);
	assign red_ny  = nose_y(red_y, red_dir);

	// red nose only while in S_RED, blue otherwise
	assign cur_nx = (state == S_RED) ? red_nx : blue_nx;
	assign cur_ny = (state == S_RED) ? red_ny : blue_ny;

	// 0 - 1 wraps to 1023, so this catches both edges
	assign cur_off = (cur_nx >= `SCREEN_W) || (cur_ny >= `SCREEN_H);

	// off-screen nose is decided without a read, park the address
	assign probe_addr = cur_off ? '0 : frame_addr(cur_nx, cur_ny);

	// lane and off-screen flag follow the address by one cycle,
	// lining up with the registered probe data
	always_ff @(posedge Clk)
	begin
		lane_q <= cur_nx[0];
		off_q  <= cur_off;
	end

	// anything but background in front of the nose blocks
	assign nose_hit = off_q || (pixel_color(probe_data.pix[lane_q]) != `COLOR_BG);

	always_ff @(posedge Clk)
	begin
		if (!rst_n)
		begin
			state         <= S_IDLE;
			collide_valid <= 1'b0;
			blue_q        <= 1'b0;
			red_q         <= 1'b0;
		end
		else
		begin
			// result strobe follows the red address cycle
			collide_valid <= (state == S_RED);
			case (state)
				S_IDLE:
				begin
					if (frame_tick)
						state <= S_BLUE;
				end
				S_BLUE:
					state <= S_RED;
				default:
					state <= S_IDLE;
			endcase
			// blue word is back while red address goes out
			if ((state == S_RED) && nose_hit)
				blue_q <= 1'b1;
			// red word is back in the strobe cycle
			if (collide_valid && nose_hit)
				red_q <= 1'b1;
		end
	end

	// sticky until reset
	assign blocked_blue = blue_q;
	// red shows in the strobe cycle, latched one edge later
	assign blocked_red = red_q || (collide_valid && nose_hit);

	// a new tick only once the sequencer is back in idle
	assert property (@(posedge Clk) disable iff (!rst_n)
		frame_tick |-> (state == S_IDLE));

endmodule

`default_nettype wire

/* color_palette.sv */
`default_nettype none

`include "tron_defs.svh"

module color_palette (
	input  logic              Clk,
	input  logic              rst_n,
	input  video_pkg::color_t color_idx,
	output logic [7:0]        vga_r,
	output logic [7:0]        vga_g,
	output logic [7:0]        vga_b
);

	// packed as r, g, b
	logic [23:0] rgb;

	// fixed table
	always_comb
	begin
		case (color_idx)
			`COLOR_BG:         rgb = 24'h000000;
			`COLOR_BLUE_TRAIL: rgb = 24'h0000ff;
			`COLOR_RED_TRAIL:  rgb = 24'hff0000;
			// bikes are the pale versions of their trails
			`COLOR_BLUE_BIKE:  rgb = 24'h8080ff;
			`COLOR_RED_BIKE:   rgb = 24'hff8080;
			// full white flash
			`COLOR_BLOCKED:    rgb = 24'hffffff;
			default:           rgb = 24'h000000;
		endcase
	end

	// output register, black out of reset
	always_ff @(posedge Clk)
	begin
		if (!rst_n)
		begin
			vga_r <= 8'd0;
			vga_g <= 8'd0;
			vga_b <= 8'd0;
		end
		else
		begin
			vga_r <= rgb[23:16];
			vga_g <= rgb[15:8];
			vga_b <= rgb[7:0];
		end
	end

endmodule

`default_nettype wire

/* frame_ram.sv */
`default_nettype none

`include "tron_defs.svh"

module frame_ram (
	input  logic                   Clk,
	// write port, from the trail writer
	input  logic                   wr_en,
	input  video_pkg::frame_addr_t wr_addr,
	input  logic [1:0]             wr_byte_en,
	input  video_pkg::frame_word_u wr_data,
	// display read port
	input  video_pkg::frame_addr_t rd_addr,
	output video_pkg::frame_word_u rd_data,
	// collision probe read port
	input  video_pkg::frame_addr_t probe_addr,
	output video_pkg::frame_word_u probe_data
);
	import video_pkg::*;

	frame_word_u mem [`FRAME_WORDS];

	// power-up contents are all background
	initial
	begin
		for (int i = 0; i < `FRAME_WORDS; i++)
			mem[i].raw = '0;
	end

	// byte-lane write
	// lane 0 holds even x, lane 1 odd x
	always_ff @(posedge Clk)
	begin
		if (wr_en)
		begin
			if (wr_byte_en[0])
				mem[wr_addr].pix[0] <= wr_data.pix[0];
			if (wr_byte_en[1])
				mem[wr_addr].pix[1] <= wr_data.pix[1];
		end
	end

	// both reads registered, one cycle latency
	// new data visible the cycle after its write
	always_ff @(posedge Clk)
	begin
		rd_data    <= mem[rd_addr];
		probe_data <= mem[probe_addr];
	end

	// writer must never run past the end of the buffer
	assert property (@(posedge Clk) wr_en |-> (wr_addr < `FRAME_WORDS));

endmodule

`default_nettype wire

/* game_pkg.sv */
`default_nettype none

package game_pkg;

	// which rider
	// blue is player 0, red is player 1
	typedef enum logic {
		PLAYER_BLUE = 1'b0,
		PLAYER_RED  = 1'b1
	} player_e;

	// heading of a bike
	// up means towards smaller y
	typedef enum logic [1:0] {
		DIR_UP    = 2'd0,
		DIR_DOWN  = 2'd1,
		DIR_LEFT  = 2'd2,
		DIR_RIGHT = 2'd3
	} dir_e;

endpackage

`default_nettype wire

/* pixel_compositor.sv */
`default_nettype none

`include "tron_defs.svh"

module pixel_compositor (
	input  logic                   Clk,
	input  logic                   rst_n,
	// raster position being drawn
	input  video_pkg::coord_t      draw_x,
	input  video_pkg::coord_t      draw_y,
	// top-left corners of the bikes
	input  video_pkg::coord_t      blue_x,
	input  video_pkg::coord_t      blue_y,
	input  video_pkg::coord_t      red_x,
	input  video_pkg::coord_t      red_y,
	input  logic                   blocked_blue,
	input  logic                   blocked_red,
	// display read port of the frame buffer
	output video_pkg::frame_addr_t rd_addr,
	input  video_pkg::frame_word_u rd_data,
	output video_pkg::color_t      color_idx
);
	import video_pkg::*;

	logic   blue_hit;
	logic   red_hit;
	logic   par_q;
	logic   blue_hit_q;
	logic   red_hit_q;
	color_t trail_color;

	// inside [sx, sx+16) x [sy, sy+16)
	// unsigned difference also rejects points left of or above the square
	function automatic logic in_square(input coord_t px, input coord_t py,
		input coord_t sx, input coord_t sy);
		coord_t dx;
		coord_t dy;
		dx = px - sx;
		dy = py - sy;
		return (dx < `BIKE_SIZE) && (dy < `BIKE_SIZE);
	endfunction

	// stage 0
	// address straight from the raster, read comes back next cycle
	assign rd_addr  = frame_addr(draw_x, draw_y);
	assign blue_hit = in_square(draw_x, draw_y, blue_x, blue_y);
	assign red_hit  = in_square(draw_x, draw_y, red_x, red_y);

	// parity and hits wait for the read data
	always_ff @(posedge Clk)
	begin
		par_q      <= draw_x[0];
		blue_hit_q <= blue_hit;
		red_hit_q  <= red_hit;
	end

	// stage 1
	// even x in the low byte, odd x in the high byte
	assign trail_color = pixel_color(rd_data.pix[par_q]);

	// flash beats blue bike, blue beats red, red beats trail
	always_ff @(posedge Clk)
	begin
		if (!rst_n)
			color_idx <= `COLOR_BG;
		else if (blocked_blue || blocked_red)
			color_idx <= `COLOR_BLOCKED;
		else if (blue_hit_q)
			color_idx <= `COLOR_BLUE_BIKE;
		else if (red_hit_q)
			color_idx <= `COLOR_RED_BIKE;
		else
			color_idx <= trail_color;
	end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/bash
# build with Verilator, run, and judge the run by its log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --assert -j 0 --top-module tb_tron_display -f verilog.f -o sim_tron \
	> sim.log 2>&1 \
	&& ./obj_dir/sim_tron >> sim.log 2>&1 \
	|| echo "Test FAILED" >> sim.log
cat sim.log
grep -q "Test FAILED" sim.log && exit 1 || exit 0

/* tb_tron_display.sv */
`default_nettype none

`include "tron_defs.svh"

module tb_tron_display;
	import video_pkg::*;
	import game_pkg::*;

	// rough cycle counts per test, doubled for the watchdog
	localparam int LEN_RESET  = 10;
	localparam int LEN_TESTS  = 20 + 40 + 60 + 20 + 60 + 250;
	localparam int MAX_CYCLES = 2 * (2 * LEN_RESET + LEN_TESTS);

	logic       Clk;
	logic       rst_n;
	logic       paint;
	player_e    paint_player;
	coord_t     paint_x;
	coord_t     paint_y;
	logic       frame_tick;
	coord_t     blue_x;
	coord_t     blue_y;
	coord_t     red_x;
	coord_t     red_y;
	dir_e       blue_dir;
	dir_e       red_dir;
	coord_t     draw_x;
	coord_t     draw_y;
	logic [7:0] vga_r;
	logic [7:0] vga_g;
	logic [7:0] vga_b;
	logic       blocked_blue;
	logic       blocked_red;
	logic       collide_valid;

	// scoreboard of painted pixels, key is y*640+x
	color_t      board [int];
	int          painted [$];
	logic        flag_blue;
	logic        flag_red;
	logic [31:0] lcg_state;
	int          cycle_count;

	tron_display i_tron_display (
		.Clk(Clk), .rst_n(rst_n),
		.paint(paint), .paint_player(paint_player),
		.paint_x(paint_x), .paint_y(paint_y),
		.frame_tick(frame_tick),
		.blue_x(blue_x), .blue_y(blue_y), .red_x(red_x), .red_y(red_y),
		.blue_dir(blue_dir), .red_dir(red_dir),
		.draw_x(draw_x), .draw_y(draw_y),
		.vga_r(vga_r), .vga_g(vga_g), .vga_b(vga_b),
		.blocked_blue(blocked_blue), .blocked_red(blocked_red),
		.collide_valid(collide_valid)
	);

	always #20 Clk = ~Clk;

	// stops a stuck run
	always @(posedge Clk)
	begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= MAX_CYCLES)
			abort_run("timeout: tests did not finish within the cycle limit");
	end

	function automatic logic [31:0] next_random();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	function automatic color_t stored_color(input int x, input int y);
		if (board.exists(y * `SCREEN_W + x))
			return board[y * `SCREEN_W + x];
		return `COLOR_BG;
	endfunction

	function automatic logic in_bike(input int x, input int y, input int sx, input int sy);
		return (x >= sx) && (x < sx + `BIKE_SIZE) && (y >= sy) && (y < sy + `BIKE_SIZE);
	endfunction

	// flash, then blue bike, then red bike, then trail
	function automatic color_t expected_color(input int x, input int y);
		if (flag_blue || flag_red)
			return `COLOR_BLOCKED;
		if (in_bike(x, y, int'(blue_x), int'(blue_y)))
			return `COLOR_BLUE_BIKE;
		if (in_bike(x, y, int'(red_x), int'(red_y)))
			return `COLOR_RED_BIKE;
		return stored_color(x, y);
	endfunction

	function automatic logic [23:0] palette_rgb(input color_t c);
		case (c)
			4'd1:    return 24'h0000ff;
			4'd2:    return 24'hff0000;
			4'd3:    return 24'h8080ff;
			4'd4:    return 24'hff8080;
			4'd7:    return 24'hffffff;
			default: return 24'h000000;
		endcase
	endfunction

	// negative nose counts as off-screen, same as the unsigned wrap
	function automatic logic nose_blocked(input int x, input int y, input dir_e d);
		int nx;
		int ny;
		nx = x + `BIKE_SIZE / 2;
		ny = y + `BIKE_SIZE / 2;
		case (d)
			DIR_UP:    ny = y - 1;
			DIR_DOWN:  ny = y + `BIKE_SIZE;
			DIR_LEFT:  nx = x - 1;
			default:   nx = x + `BIKE_SIZE;
		endcase
		if (nx < 0 || nx >= `SCREEN_W || ny < 0 || ny >= `SCREEN_H)
			return 1'b1;
		return stored_color(nx, ny) != `COLOR_BG;
	endfunction

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Test FAILED");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got === exp)
		else
			abort_run($sformatf("Error: time %0t %s got %0h expected %0h",
				$time, name, got, exp));
	endtask

	task automatic check_rgb(input logic [23:0] exp);
		check_value("vga_r", vga_r, exp[23:16]);
		check_value("vga_g", vga_g, exp[15:8]);
		check_value("vga_b", vga_b, exp[7:0]);
	endtask

	// inputs change 2 units after the rising edge
	task automatic tick();
		@(posedge Clk);
		#2;
	endtask

	task automatic apply_reset();
		rst_n = 1'b0;
		repeat (5) tick();
		rst_n = 1'b1;
		flag_blue = 1'b0;
		flag_red  = 1'b0;
	endtask

	task automatic paint_pixel(input int x, input int y, input player_e p);
		tick();
		paint        = 1'b1;
		paint_player = p;
		paint_x      = coord_t'(x);
		paint_y      = coord_t'(y);
		board[y * `SCREEN_W + x] = (p == PLAYER_RED) ? `COLOR_RED_TRAIL : `COLOR_BLUE_TRAIL;
	endtask

	task automatic paint_idle();
		tick();
		paint = 1'b0;
	endtask

	task automatic scan_pixel(input int x, input int y);
		logic [23:0] exp;
		tick();
		draw_x = coord_t'(x);
		draw_y = coord_t'(y);
		exp = palette_rgb(expected_color(x, y));
		repeat (3) tick();
		check_rgb(exp);
	endtask

	task automatic place_bikes(input int bx, input int by, input dir_e bd,
		input int rx, input int ry, input dir_e rd);
		tick();
		blue_x   = coord_t'(bx);
		blue_y   = coord_t'(by);
		blue_dir = bd;
		red_x    = coord_t'(rx);
		red_y    = coord_t'(ry);
		red_dir  = rd;
	endtask

	// tick, then result strobe exactly three cycles later
	task automatic run_probe();
		flag_blue = flag_blue | nose_blocked(int'(blue_x), int'(blue_y), blue_dir);
		flag_red  = flag_red | nose_blocked(int'(red_x), int'(red_y), red_dir);
		tick();
		frame_tick = 1'b1;
		tick();
		frame_tick = 1'b0;
		check_value("collide_valid", collide_valid, 0);
		tick();
		check_value("collide_valid", collide_valid, 0);
		tick();
		check_value("collide_valid", collide_valid, 1);
		check_value("blocked_blue", blocked_blue, flag_blue);
		check_value("blocked_red", blocked_red, flag_red);
		tick();
		// strobe is one cycle, flags hold
		check_value("collide_valid", collide_valid, 0);
		check_value("blocked_blue", blocked_blue, flag_blue);
		check_value("blocked_red", blocked_red, flag_red);
	endtask

	task automatic test_reset_state();
		check_rgb(24'h000000);
		check_value("collide_valid", collide_valid, 0);
		check_value("blocked_blue", blocked_blue, 0);
		check_value("blocked_red", blocked_red, 0);
		scan_pixel(5, 5);
	endtask

	task automatic test_trail_paint();
		logic [23:0] old_rgb;
		paint_pixel(100, 50, PLAYER_BLUE);
		paint_idle();
		scan_pixel(102, 50);
		old_rgb = palette_rgb(expected_color(102, 50));
		// new pixel must not show before cycle 3
		tick();
		draw_x = 10'd100;
		draw_y = 10'd50;
		repeat (2) tick();
		check_rgb(old_rgb);
		tick();
		check_rgb(palette_rgb(expected_color(100, 50)));
		// odd neighbour shares the word
		paint_pixel(101, 50, PLAYER_RED);
		paint_idle();
		scan_pixel(101, 50);
		scan_pixel(100, 50);
	endtask

	task automatic test_sprite_priority();
		place_bikes(200, 100, DIR_RIGHT, 208, 108, DIR_DOWN);
		paint_pixel(220, 120, PLAYER_BLUE);
		paint_pixel(230, 110, PLAYER_RED);
		paint_idle();
		// blue only, overlap, red over a trail, bare trail
		scan_pixel(202, 102);
		scan_pixel(210, 110);
		scan_pixel(220, 120);
		scan_pixel(230, 110);
	endtask

	task automatic test_collision();
		// trail in front of blue, red heads off the left edge
		paint_pixel(216, 108, PLAYER_RED);
		paint_idle();
		place_bikes(200, 100, DIR_RIGHT, 0, 200, DIR_LEFT);
		run_probe();
		scan_pixel(100, 50);
		scan_pixel(5, 5);
		scan_pixel(216, 108);
		scan_pixel(205, 105);
		apply_reset();
		check_value("blocked_blue", blocked_blue, 0);
		check_value("blocked_red", blocked_red, 0);
	endtask

	task automatic test_random_trails();
		logic [31:0] r;
		int          x;
		int          y;
		for (int i = 0; i < 40; i++)
		begin
			r = next_random();
			x = int'((r >> 8) % 32'd640);
			y = int'((r >> 18) % 32'd480);
			painted.push_back(y * `SCREEN_W + x);
			paint_pixel(x, y, r[4] ? PLAYER_RED : PLAYER_BLUE);
		end
		paint_idle();
		foreach (painted[i])
			scan_pixel(painted[i] % `SCREEN_W, painted[i] / `SCREEN_W);
	endtask

	initial
	begin
		Clk          = 1'b0;
		rst_n        = 1'b0;
		paint        = 1'b0;
		paint_player = PLAYER_BLUE;
		paint_x      = '0;
		paint_y      = '0;
		frame_tick   = 1'b0;
		blue_x       = 10'd400;
		blue_y       = 10'd300;
		red_x        = 10'd440;
		red_y        = 10'd300;
		blue_dir     = DIR_RIGHT;
		red_dir      = DIR_LEFT;
		draw_x       = '0;
		draw_y       = '0;
		flag_blue    = 1'b0;
		flag_red     = 1'b0;
		lcg_state    = 32'h8052;
		cycle_count  = 0;
		apply_reset();
		test_reset_state();
		test_trail_paint();
		test_sprite_priority();
		// both noses on background here
		run_probe();
		test_collision();
		test_random_trails();
		$display("Test OK");
		$finish;
	end

endmodule

`default_nettype wire

/* trail_writer.sv */
`default_nettype none

`include "tron_defs.svh"

module trail_writer (
	input  logic                   Clk,
	input  logic                   rst_n,
	// paint strobe from the game logic
	input  logic                   paint,
	input  game_pkg::player_e      paint_player,
	input  video_pkg::coord_t      paint_x,
	input  video_pkg::coord_t      paint_y,
	// registered write into the frame buffer
	output logic                   wr_en,
	output video_pkg::frame_addr_t wr_addr,
	output logic [1:0]             wr_byte_en,
	output video_pkg::frame_word_u wr_data
);
	import video_pkg::*;
	import game_pkg::*;

	color_t trail_color;

	// each rider leaves its own trail color
	always_comb
	begin
		if (paint_player == PLAYER_RED)
			trail_color = `COLOR_RED_TRAIL;
		else
			trail_color = `COLOR_BLUE_TRAIL;
	end

	// write strobe, one cycle behind paint
	always_ff @(posedge Clk)
	begin
		if (!rst_n)
			wr_en <= 1'b0;
		else
			wr_en <= paint;
	end

	// address, lane and data
	// color goes to both lanes, byte enable picks the one by x parity
	always_ff @(posedge Clk)
	begin
		wr_addr    <= frame_addr(paint_x, paint_y);
		wr_byte_en <= paint_x[0] ? 2'b10 : 2'b01;
		wr_data.raw <= {make_pixel(trail_color), make_pixel(trail_color)};
	end

	// paint only ever lands on the visible raster
	assert property (@(posedge Clk) disable iff (!rst_n)
		paint |-> (paint_x < `SCREEN_W) && (paint_y < `SCREEN_H));

endmodule

`default_nettype wire

/* tron_defs.svh */
`ifndef TRON_DEFS_SVH
`define TRON_DEFS_SVH

// visible raster in pixels
`define SCREEN_W 640
`define SCREEN_H 480

// bikes are solid squares of this edge
`define BIKE_SIZE 16

// two pixels per 16-bit word, so 320 words per line
`define FRAME_WORDS 153600

// color indices as stored in the frame buffer
`define COLOR_BG         4'd0
`define COLOR_BLUE_TRAIL 4'd1
`define COLOR_RED_TRAIL  4'd2
`define COLOR_BLUE_BIKE  4'd3
`define COLOR_RED_BIKE   4'd4
// indices 5 and 6 unused, palette shows them black
`define COLOR_BLOCKED    4'd7

`endif

/* tron_display.sv */
`default_nettype none

module tron_display (
	input  logic               Clk,
	input  logic               rst_n,
	// trail paint
	input  logic               paint,
	input  game_pkg::player_e  paint_player,
	input  video_pkg::coord_t  paint_x,
	input  video_pkg::coord_t  paint_y,
	// per-frame collision probe
	input  logic               frame_tick,
	input  video_pkg::coord_t  blue_x,
	input  video_pkg::coord_t  blue_y,
	input  video_pkg::coord_t  red_x,
	input  video_pkg::coord_t  red_y,
	input  game_pkg::dir_e     blue_dir,
	input  game_pkg::dir_e     red_dir,
	// raster scan
	input  video_pkg::coord_t  draw_x,
	input  video_pkg::coord_t  draw_y,
	output logic [7:0]         vga_r,
	output logic [7:0]         vga_g,
	output logic [7:0]         vga_b,
	output logic               blocked_blue,
	output logic               blocked_red,
	output logic               collide_valid
);
	import video_pkg::*;

	// write port
	logic        wr_en;
	frame_addr_t wr_addr;
	logic [1:0]  wr_byte_en;
	frame_word_u wr_data;
	// display and probe reads
	frame_addr_t rd_addr;
	frame_word_u rd_data;
	frame_addr_t probe_addr;
	frame_word_u probe_data;
	// composed index into the palette
	color_t      color_idx;

	trail_writer i_trail_writer (
		.Clk(Clk), .rst_n(rst_n),
		.paint(paint), .paint_player(paint_player),
		.paint_x(paint_x), .paint_y(paint_y),
		.wr_en(wr_en), .wr_addr(wr_addr),
		.wr_byte_en(wr_byte_en), .wr_data(wr_data)
	);

	frame_ram i_frame_ram (
		.Clk(Clk),
		.wr_en(wr_en), .wr_addr(wr_addr),
		.wr_byte_en(wr_byte_en), .wr_data(wr_data),
		.rd_addr(rd_addr), .rd_data(rd_data),
		.probe_addr(probe_addr), .probe_data(probe_data)
	);

	collision_detect i_collision_detect (
		.Clk(Clk), .rst_n(rst_n), .frame_tick(frame_tick),
		.blue_x(blue_x), .blue_y(blue_y), .red_x(red_x), .red_y(red_y),
		.blue_dir(blue_dir), .red_dir(red_dir),
		.probe_addr(probe_addr), .probe_data(probe_data),
		.blocked_blue(blocked_blue), .blocked_red(blocked_red),
		.collide_valid(collide_valid)
	);

	// blocked flags turn the whole screen white
	pixel_compositor i_pixel_compositor (
		.Clk(Clk), .rst_n(rst_n),
		.draw_x(draw_x), .draw_y(draw_y),
		.blue_x(blue_x), .blue_y(blue_y), .red_x(red_x), .red_y(red_y),
		.blocked_blue(blocked_blue), .blocked_red(blocked_red),
		.rd_addr(rd_addr), .rd_data(rd_data),
		.color_idx(color_idx)
	);

	color_palette i_color_palette (
		.Clk(Clk), .rst_n(rst_n),
		.color_idx(color_idx),
		.vga_r(vga_r), .vga_g(vga_g), .vga_b(vga_b)
	);

endmodule

`default_nettype wire

/* verilog.f */
+incdir+.
video_pkg.sv
game_pkg.sv
frame_ram.sv
trail_writer.sv
collision_detect.sv
pixel_compositor.sv
color_palette.sv
tron_display.sv
tb_tron_display.sv

/* video_pkg.sv */
`default_nettype none

`include "tron_defs.svh"

package video_pkg;

	// palette index, 16 colors max
	typedef logic [3:0] color_t;

	// one pixel per byte, upper nibble always zero
	typedef logic [7:0] pixel_t;

	// screen coordinate, wide enough for 0..639
	typedef logic [9:0] coord_t;

	// word address into the frame buffer
	typedef logic [17:0] frame_addr_t;

	// stored word, seen either whole or as two pixel bytes
	// pix[1] is the odd pixel, pix[0] the even one
	typedef union packed {
		logic [15:0]  raw;
		pixel_t [1:0] pix;
	} frame_word_u;

	// word address of a pixel, y*320 + x/2
	function automatic frame_addr_t frame_addr(input coord_t x, input coord_t y);
		frame_addr_t row_base;
		row_base = frame_addr_t'(y) * frame_addr_t'(`SCREEN_W / 2);
		return row_base + frame_addr_t'(x >> 1);
	endfunction

	// color index out of a pixel byte
	function automatic color_t pixel_color(input pixel_t p);
		return p[3:0];
	endfunction

	// pixel byte from a color index
	function automatic pixel_t make_pixel(input color_t c);
		return {4'h0, c};
	endfunction

endpackage

`default_nettype wire
